// ==== logic/report_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clocking and size constants for the CHERI fault reporter.
// Imported by the RTL and by the testbench.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package report_cfg_pkg;

  // Number of CHERI violation flags.
  // One flag per violation class, Bounds up to Permit Acc Sys Regs.
  parameter int unsigned FaultWidth = 9;

  // System clock frequency in Hz.
  parameter int unsigned SysClkFreq = 40_000_000;

  // Serial line rate of the report channel.
  parameter int unsigned BaudRate = 921_600;

  // Clock cycles per UART bit.
  // Integer division truncates 43.4 down to 43.
  parameter int unsigned DefaultClkPerBit = SysClkFreq / BaudRate;

  // Width of a violation index.
  parameter int unsigned FaultIdxWidth = $clog2(FaultWidth);

  // Index of one violation flag.
  typedef logic [FaultIdxWidth-1:0] fault_idx_t;

endpackage

`default_nettype wire

// ==== logic/report_frame_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART frame layout and report sequencer states.
// Used by the sequencer, the shifter and the testbench checks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package report_frame_pkg;

  // Data bits per character.
  parameter int unsigned ByteWidth = 8;

  // One start bit, the data bits and one stop bit.
  // No parity bit, so the character format is 8N1.
  parameter int unsigned FrameBits = ByteWidth + 2;

  // Line level of the start bit.
  parameter logic StartBit = 1'b0;

  // Line level of the stop bit.
  // Same level as an idle line.
  parameter logic StopBit = 1'b1;

  // First byte of every report.
  // ASCII exclamation mark.
  parameter logic [ByteWidth-1:0] MarkerByte = 8'h21;

  // Report sequencer state.
  // IDLE waits for an index.
  // SEND_MARKER offers the marker byte.
  // SEND_INDEX offers the violation index.
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    SEND_MARKER = 2'd1,
    SEND_INDEX  = 2'd2
  } report_state_e;

endpackage

`default_nettype wire

// ==== logic/fault_capture.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Latches the first occurrence of each CHERI violation flag.
// Offers the lowest pending index to the report sequencer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fault_capture
  import report_cfg_pkg::*;
#(
  parameter int unsigned FaultWidth = report_cfg_pkg::FaultWidth
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [FaultWidth-1:0] fault_i,
  input  logic                  idx_ready_i,
  output logic                  idx_valid_o,
  output fault_idx_t            idx_o,
  output logic [FaultWidth-1:0] seen_o
);

  logic [FaultWidth-1:0] seen_q;
  logic [FaultWidth-1:0] pending_q;
  logic [FaultWidth-1:0] new_fault;
  logic [FaultWidth-1:0] clr_mask;
  fault_idx_t            pick;
  logic                  locked_q;
  fault_idx_t            locked_idx_q;
  logic                  take;

  // Flags pulse for LED modulation, so only unseen bits are new.
  assign new_fault = fault_i & ~seen_q;

  // Lowest pending index wins.
  // The loop runs downwards so the last match is the lowest bit.
  always_comb begin
    pick = '0;
    for (int i = FaultWidth - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        pick = fault_idx_t'(i);
      end
    end
  end

  assign idx_valid_o = |pending_q;
  // A stalled offer keeps its index even if a lower bit arrives.
  assign idx_o       = locked_q ? locked_idx_q : pick;
  assign take        = idx_valid_o && idx_ready_i;

  // One-hot clear of the accepted bit.
  always_comb begin
    clr_mask = '0;
    if (take) begin
      clr_mask[idx_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q    <= '0;
      pending_q <= '0;
      locked_q  <= 1'b0;
    end else begin
      seen_q    <= seen_q | new_fault;
      pending_q <= (pending_q & ~clr_mask) | new_fault;
      if (take) begin
        locked_q <= 1'b0;
      end else if (idx_valid_o) begin
        locked_q <= 1'b1;
      end
    end
  end

  // Captured once per stalled offer.
  always_ff @(posedge clk_i) begin
    if (idx_valid_o && !idx_ready_i && !locked_q) begin
      locked_idx_q <= pick;
    end
  end

  assign seen_o = seen_q;

endmodule

`default_nettype wire

// ==== logic/baud_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bit timer for the UART shifter.
// Pulses once per bit period while a character is on the line.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module baud_timer #(
  parameter int unsigned ClkPerBit = 43
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic busy_i,
  output logic bit_tick_o
);

  // At least one bit, even for a divide-by-one timer.
  localparam int unsigned CntWidth = (ClkPerBit > 1) ? $clog2(ClkPerBit) : 1;
  localparam logic [CntWidth-1:0] LastCnt = CntWidth'(ClkPerBit - 1);

  logic [CntWidth-1:0] cnt_q;
  logic                at_end;

  assign at_end = (cnt_q == LastCnt);

  // Held at zero while idle so the start bit gets a full period.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!busy_i || at_end) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Last cycle of each bit period.
  assign bit_tick_o = busy_i && at_end;

endmodule

`default_nettype wire

// ==== logic/report_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Report sequencer.
// Turns each accepted violation index into a marker byte and an index byte.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module report_fsm
  import report_cfg_pkg::*;
  import report_frame_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 idx_valid_i,
  input  fault_idx_t           idx_i,
  input  logic                 byte_ready_i,
  output logic                 idx_ready_o,
  output logic                 byte_valid_o,
  output logic [ByteWidth-1:0] byte_o
);

  report_state_e state_q;
  report_state_e state_d;
  fault_idx_t    idx_q;
  logic          idx_take;
  logic          byte_take;

  // New indices are taken only between reports.
  assign idx_ready_o  = (state_q == IDLE);
  assign idx_take     = idx_valid_i && idx_ready_o;

  // Both send states offer a byte.
  assign byte_valid_o = (state_q != IDLE);
  assign byte_take    = byte_valid_o && byte_ready_i;

  // Marker first, then the stored index zero-extended.
  always_comb begin
    if (state_q == SEND_MARKER) begin
      byte_o = MarkerByte;
    end else begin
      byte_o = ByteWidth'(idx_q);
    end
  end

  // Each byte is held until the shifter takes it.
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (idx_take) begin
          state_d = SEND_MARKER;
        end
      end
      SEND_MARKER: begin
        if (byte_take) begin
          state_d = SEND_INDEX;
        end
      end
      SEND_INDEX: begin
        if (byte_take) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Index of the report in progress.
  always_ff @(posedge clk_i) begin
    if (idx_take) begin
      idx_q <= idx_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_tx_shifter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmit shifter.
// Sends one byte as an 8N1 character, one bit per tick from the timer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module uart_tx_shifter
  import report_frame_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 byte_valid_i,
  input  logic [ByteWidth-1:0] byte_i,
  input  logic                 bit_tick_i,
  output logic                 byte_ready_o,
  output logic                 busy_o,
  output logic                 tx_o
);

  localparam int unsigned BitCntWidth = $clog2(FrameBits);
  localparam logic [BitCntWidth-1:0] LastBit = BitCntWidth'(FrameBits - 1);

  logic [FrameBits-1:0]   frame_q;
  logic [BitCntWidth-1:0] bit_cnt_q;
  logic                   busy_q;
  logic                   accept;

  assign accept = byte_valid_i && !busy_q;

  // Bit 0 of the frame drives the line.
  // Ones shift in behind it, so the line idles high after the stop bit.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      frame_q   <= '1;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
    end else if (accept) begin
      frame_q   <= {StopBit, byte_i, StartBit};
      bit_cnt_q <= '0;
      busy_q    <= 1'b1;
    end else if (busy_q && bit_tick_i) begin
      frame_q <= {1'b1, frame_q[FrameBits-1:1]};
      // Tick at the end of the stop bit closes the character.
      if (bit_cnt_q == LastBit) begin
        bit_cnt_q <= '0;
        busy_q    <= 1'b0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  assign tx_o         = frame_q[0];
  assign busy_o       = busy_q;
  assign byte_ready_o = !busy_q;

endmodule

`default_nettype wire

// ==== logic/fault_report_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CHERI fault reporter top level.
// Sends a two-byte UART report for the first occurrence of each violation.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module fault_report_top
  import report_cfg_pkg::*;
  import report_frame_pkg::*;
#(
  parameter int unsigned FaultWidth = report_cfg_pkg::FaultWidth,
  parameter int unsigned ClkPerBit  = DefaultClkPerBit
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [FaultWidth-1:0] fault_i,
  output logic                  tx_o,
  output logic [FaultWidth-1:0] reported_o
);

  // Capture to sequencer.
  logic                 idx_valid;
  logic                 idx_ready;
  fault_idx_t           idx;

  // Sequencer to shifter.
  logic                 byte_valid;
  logic                 byte_ready;
  logic [ByteWidth-1:0] byte_data;

  // Shifter and timer.
  logic                 busy;
  logic                 bit_tick;

  // The seen mask doubles as the reported mask.
  fault_capture #(
    .FaultWidth ( FaultWidth )
  ) i_fault_capture (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .fault_i     ( fault_i    ),
    .idx_ready_i ( idx_ready  ),
    .idx_valid_o ( idx_valid  ),
    .idx_o       ( idx        ),
    .seen_o      ( reported_o )
  );

  report_fsm i_report_fsm (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .idx_valid_i  ( idx_valid  ),
    .idx_i        ( idx        ),
    .byte_ready_i ( byte_ready ),
    .idx_ready_o  ( idx_ready  ),
    .byte_valid_o ( byte_valid ),
    .byte_o       ( byte_data  )
  );

  baud_timer #(
    .ClkPerBit ( ClkPerBit )
  ) i_baud_timer (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .busy_i     ( busy     ),
    .bit_tick_o ( bit_tick )
  );

  uart_tx_shifter i_uart_tx_shifter (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .byte_valid_i ( byte_valid ),
    .byte_i       ( byte_data  ),
    .bit_tick_i   ( bit_tick   ),
    .byte_ready_o ( byte_ready ),
    .busy_o       ( busy       ),
    .tx_o         ( tx_o       )
  );

endmodule

`default_nettype wire

// ==== tests/tb_uart_monitor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver model for the fault reporter testbench.
// Decodes 8N1 characters on rx_i and pulses byte_valid_o per byte.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_uart_monitor
  import report_frame_pkg::*;
#(
  parameter int unsigned ClkPerBit = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rx_i,
  output logic                 byte_valid_o,
  output logic [ByteWidth-1:0] byte_o,
  output int                   frame_errors_o
);

  // Line level seen at the previous clock edge.
  logic                 line_q;
  logic [ByteWidth-1:0] data;

  // Samples at rising edges, where the registered line is stable.
  initial begin
    byte_valid_o   = 1'b0;
    byte_o         = '0;
    frame_errors_o = 0;
    line_q         = 1'b1;
    data           = '0;
    forever begin
      @(posedge clk_i);
      byte_valid_o <= 1'b0;
      // Falling edge of the start bit.
      if (rst_ni && line_q === 1'b1 && rx_i === 1'b0) begin
        // Move to the middle of the start bit.
        repeat (ClkPerBit / 2) @(posedge clk_i);
        if (rx_i !== 1'b0) begin
          $display("Framing error: start bit was not low at its middle");
          frame_errors_o = frame_errors_o + 1;
        end
        // Data bits, LSB first.
        for (int b = 0; b < ByteWidth; b++) begin
          repeat (ClkPerBit) @(posedge clk_i);
          data[b] = rx_i;
        end
        repeat (ClkPerBit) @(posedge clk_i);
        if (rx_i !== 1'b1) begin
          $display("Framing error: stop bit was not high at its middle");
          frame_errors_o = frame_errors_o + 1;
        end
        byte_o       <= data;
        byte_valid_o <= 1'b1;
      end
      line_q = rx_i;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_fault_report.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CHERI fault reporter.
// Applies a table of LED-style violation patterns and checks the
// UART reports and the reported mask.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_fault_report
  import report_cfg_pkg::*;
  import report_frame_pkg::*;
;

  localparam int unsigned ClkPerBit   = 8;
  localparam int          NumRows     = 8;
  localparam logic [31:0] Seed        = 32'h254ee4ae;
  // Two characters of silence, with some slack.
  localparam int          QuietCycles = 24 * ClkPerBit;
  localparam int WatchdogCycles = NumRows * (FaultWidth + 1) * 20 * ClkPerBit
                                  + NumRows * 1000 + 100;

  logic                  clk_i;
  logic                  rst_ni;
  logic [FaultWidth-1:0] fault_i;
  logic                  tx_o;
  logic [FaultWidth-1:0] reported_o;

  logic                  mon_valid;
  logic [ByteWidth-1:0]  mon_byte;
  int                    frame_errors;

  // Stimulus table.
  string                 row_name    [NumRows];
  logic [FaultWidth-1:0] row_pattern [NumRows];
  int                    row_reps    [NumRows];
  logic [FaultWidth-1:0] row_expect  [NumRows];
  bit                    row_wait    [NumRows];

  logic [ByteWidth-1:0]  exp_q [$];
  logic [ByteWidth-1:0]  rx_q [$];
  logic [FaultWidth-1:0] seen_model;
  logic [31:0]           lfsr_q;
  int                    errors;

  fault_report_top #(
    .FaultWidth ( FaultWidth ),
    .ClkPerBit  ( ClkPerBit  )
  ) i_fault_report_top (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .fault_i    ( fault_i    ),
    .tx_o       ( tx_o       ),
    .reported_o ( reported_o )
  );

  tb_uart_monitor #(
    .ClkPerBit ( ClkPerBit )
  ) i_uart_monitor (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .rx_i           ( tx_o         ),
    .byte_valid_o   ( mon_valid    ),
    .byte_o         ( mon_byte     ),
    .frame_errors_o ( frame_errors )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Decoded bytes wait here until a row compares them.
  always @(posedge clk_i) begin
    if (mon_valid) begin
      rx_q.push_back(mon_byte);
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", WatchdogCycles);
    $display("sim failed");
    $finish;
  end

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = (value << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic set_row(input int r, input string name, input logic [FaultWidth-1:0] pat,
                         input int reps, input logic [FaultWidth-1:0] exp, input bit wt);
    row_name[r]    = name;
    row_pattern[r] = pat;
    row_reps[r]    = reps;
    row_expect[r]  = exp;
    row_wait[r]    = wt;
  endtask

  // Overlap rows raise new bits while bit 8 is still on the line.
  task automatic load_table();
    set_row(0, "idle",      9'h000, 1, 9'h000, 1'b1);
    set_row(1, "single",    9'h004, 3, 9'h004, 1'b1);
    set_row(2, "multi",     9'h0a1, 2, 9'h0a1, 1'b1);
    set_row(3, "repeat",    9'h004, 4, 9'h000, 1'b1);
    set_row(4, "overlap_a", 9'h100, 2, 9'h100, 1'b0);
    set_row(5, "overlap_b", 9'h04a, 3, 9'h04a, 1'b1);
    set_row(6, "mixed",     9'h1f0, 2, 9'h010, 1'b1);
    set_row(7, "all_seen",  9'h1ff, 2, 9'h000, 1'b1);
  endtask

  // On and off phases mimic LED modulation.
  task automatic apply_row(input int r);
    int hold;
    int gap;
    for (int rep = 0; rep < row_reps[r]; rep++) begin
      random_bits(4, hold);
      random_bits(4, gap);
      fault_i <= row_pattern[r];
      repeat (hold + 1) @(posedge clk_i);
      fault_i <= '0;
      repeat (gap + 1) @(posedge clk_i);
    end
  endtask

  task automatic wait_for_bytes(input int r);
    int limit;
    int cycles;
    limit  = (exp_q.size() * 10 + 40) * ClkPerBit;
    cycles = 0;
    while (rx_q.size() < exp_q.size() && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    if (rx_q.size() < exp_q.size()) begin
      $display("%s: only %0d of %0d bytes arrived within %0d cycles",
               row_name[r], rx_q.size(), exp_q.size(), limit);
      errors++;
    end
  endtask

  task automatic compare_bytes(input int r);
    logic [ByteWidth-1:0] want;
    logic [ByteWidth-1:0] got;
    while (exp_q.size() > 0) begin
      want = exp_q.pop_front();
      if (rx_q.size() == 0) begin
        $display("%s: expected byte 0x%02h was never received", row_name[r], want);
        errors++;
      end else begin
        got = rx_q.pop_front();
        if (got !== want) begin
          $display("ERR %s: byte expected 0x%02h actual 0x%02h", row_name[r], want, got);
          errors++;
        end
      end
    end
  endtask

  // No further report may follow, and the mask must match the model.
  task automatic check_quiet(input int r);
    repeat (QuietCycles) @(posedge clk_i);
    if (rx_q.size() != 0) begin
      $display("%s: %0d unexpected bytes arrived, first one 0x%02h",
               row_name[r], rx_q.size(), rx_q[0]);
      errors++;
      rx_q.delete();
    end
    if (reported_o !== seen_model) begin
      $display("ERR %s: reported_o expected 0x%03h actual 0x%03h",
               row_name[r], seen_model, reported_o);
      errors++;
    end
    if (tx_o !== 1'b1) begin
      $display("%s: serial line is not idle high after the reports", row_name[r]);
      errors++;
    end
  endtask

  initial begin
    rst_ni     = 1'b0;
    fault_i    = '0;
    errors     = 0;
    seen_model = '0;
    lfsr_q     = Seed;
    load_table();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (tx_o !== 1'b1) begin
      $display("reset: serial line is not high after reset");
      errors++;
    end
    if (reported_o !== '0) begin
      $display("ERR reset: reported_o expected 0x000 actual 0x%03h", reported_o);
      errors++;
    end
    for (int r = 0; r < NumRows; r++) begin
      // One marker and one index byte per new violation, lowest first.
      for (int i = 0; i < FaultWidth; i++) begin
        if (row_expect[r][i]) begin
          exp_q.push_back(MarkerByte);
          exp_q.push_back(ByteWidth'(i));
        end
      end
      seen_model = seen_model | row_pattern[r];
      apply_row(r);
      if (row_wait[r]) begin
        wait_for_bytes(r);
        compare_bytes(r);
        check_quiet(r);
      end
    end
    $display("Done: %0d check errors, %0d framing errors", errors, frame_errors);
    if (errors == 0 && frame_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/report_cfg_pkg.sv
logic/report_frame_pkg.sv
logic/fault_capture.sv
logic/baud_timer.sv
logic/report_fsm.sv
logic/uart_tx_shifter.sv
logic/fault_report_top.sv
tests/tb_uart_monitor.sv
tests/tb_fault_report.sv

// ==== Makefile ====
# Verilator simulation of the CHERI fault reporter testbench.
# The run passes only if the log holds the pass line.

TOP := tb_fault_report

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o Vsim
	./obj_dir/Vsim | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
